// File: verilog.f
hw/burst_pkg.sv
hw/burst_split.sv
hw/beat_counter.sv
hw/burst_ctrl.sv
hw/burst_read_top.sv
verif/tb_clock.sv
verif/burst_assertions.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= ** PASS **

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qF '$(PASS_MSG)'; then \
		exit 0; \
	else \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_top.sv
module tb_top;

   localparam int N_TESTS = 40;
   localparam int LIMIT   = N_TESTS * 300 * 20;  // cycles

   logic                clk;
   logic                rst;
   logic                cmd_valid;
   burst_pkg::cmd_t     cmd;
   logic                cmd_ready;
   logic                mem_req_valid;
   burst_pkg::mem_req_t mem_req;
   logic                mem_req_ready;
   logic                mem_data_valid;
   burst_pkg::word_t    mem_data;
   logic                mem_data_ready;
   logic                out_valid;
   burst_pkg::word_t    out_data;
   logic                out_last;
   logic                out_ready;
   int                  tests_done;
   int                  errors;

   burst_pkg::word_t    mem [0:16383];  // 64 KiB image
   logic [31:0]         lfsr_q;

   tb_clock u_clk (.clk_o(clk));

   burst_read_top DUT (
      .clk_i(clk), .rst_i(rst),
      .cmd_valid_i(cmd_valid), .cmd_i(cmd), .cmd_ready_o(cmd_ready),
      .mem_req_valid_o(mem_req_valid), .mem_req_o(mem_req), .mem_req_ready_i(mem_req_ready),
      .mem_data_valid_i(mem_data_valid), .mem_data_i(mem_data),
      .mem_data_ready_o(mem_data_ready),
      .out_valid_o(out_valid), .out_data_o(out_data), .out_last_o(out_last),
      .out_ready_i(out_ready)
   );

   tb_checker u_chk (
      .clk_i(clk), .rst_i(rst),
      .cmd_valid_i(cmd_valid), .cmd_i(cmd), .cmd_ready_i(cmd_ready),
      .mem_req_valid_i(mem_req_valid), .mem_req_i(mem_req), .mem_req_ready_i(mem_req_ready),
      .out_valid_i(out_valid), .out_data_i(out_data), .out_last_i(out_last),
      .out_ready_i(out_ready), .tests_o(tests_done), .errors_o(errors)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
   endfunction

   // one LFSR step per bit
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic drive_commands();
      logic [31:0] r;
      for (int t = 0; t < N_TESTS; t++) begin
         take_bits(2, r);
         repeat (r[1] ? int'(r[0]) : 0) begin
            @(posedge clk);
            #1;
         end
         take_bits(13, r);
         cmd.byte_addr = {1'b0, r[12:0], 2'b00} | burst_pkg::byte_addr_t'(t % 4);
         take_bits(8, r);
         cmd.n_words = burst_pkg::beat_cnt_t'((r[7:0] == 8'd0) ? 8'd1 : r[7:0]);
         cmd_valid = 1'b1;
         @(posedge clk);
         while (!cmd_ready) @(posedge clk);
         #1;
         cmd_valid = 1'b0;
      end
   endtask

   task automatic respond_memory();
      logic [31:0]          r;
      burst_pkg::word_addr_t wa;
      burst_pkg::beat_cnt_t  nb;
      forever begin
         while (!mem_req_valid) begin
            @(posedge clk);
            #1;
         end
         take_bits(2, r);
         repeat (int'(r[1:0])) begin
            @(posedge clk);
            #1;
         end
         mem_req_ready = 1'b1;
         wa = mem_req.word_addr;
         nb = mem_req.n_beats;
         @(posedge clk);
         #1;
         mem_req_ready = 1'b0;
         for (int b = 0; b < int'(nb); b++) begin
            take_bits(2, r);
            if (r[1:0] == 2'b11) begin
               repeat (2) @(posedge clk);  // valid gap
               #1;
            end
            mem_data_valid = 1'b1;
            mem_data       = mem[wa + burst_pkg::word_addr_t'(b)];
            @(posedge clk);
            while (!mem_data_ready) @(posedge clk);
            #1;
            mem_data_valid = 1'b0;
         end
      end
   endtask

   task automatic drive_sink();
      logic [31:0] r;
      forever begin
         @(posedge clk);
         #1;
         take_bits(3, r);
         out_ready = (r[2:0] != 3'd0);
      end
   endtask

   initial begin
      logic [31:0] v;
      rst            = 1'b1;
      cmd_valid      = 1'b0;
      cmd            = '0;
      mem_req_ready  = 1'b0;
      mem_data_valid = 1'b0;
      mem_data       = '0;
      out_ready      = 1'b0;
      lfsr_q         = 32'he67583b5;
      for (int i = 0; i < 16384; i++) begin
         take_bits(32, v);
         mem[i] = v;
      end
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      fork
         drive_commands();
         respond_memory();
         drive_sink();
      join_none
      while (tests_done < N_TESTS) @(posedge clk);
      repeat (4) @(posedge clk);
      $display("tests %0d errors %0d", tests_done, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin
      #(LIMIT * 4);
      $display("timeout after %0d cycles with %0d of %0d tests done", LIMIT, tests_done,
               N_TESTS);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: verif/tb_checker.sv
module tb_checker (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                cmd_valid_i,
   input  burst_pkg::cmd_t     cmd_i,
   input  logic                cmd_ready_i,
   input  logic                mem_req_valid_i,
   input  burst_pkg::mem_req_t mem_req_i,
   input  logic                mem_req_ready_i,
   input  logic                out_valid_i,
   input  burst_pkg::word_t    out_data_i,
   input  logic                out_last_i,
   input  logic                out_ready_i,
   output int                  tests_o,
   output int                  errors_o
);

   burst_pkg::cmd_t cmd_q;
   int              k;
   int              test_err;
   logic            ready_due;  // cmd_ready_o must be back on this edge

   // four image bytes starting at a, little endian
   function automatic burst_pkg::word_t expected_word(input burst_pkg::byte_addr_t a);
      burst_pkg::word_t      w;
      burst_pkg::byte_addr_t b;
      for (int i = 0; i < 4; i++) begin
         b = a + burst_pkg::byte_addr_t'(i);
         w[8*i +: 8] = tb_top.mem[b[15:2]][{b[1:0], 3'b000} +: 8];
      end
      return w;
   endfunction

   task automatic report_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("error %s: got %h expected %h (test %0d word %0d)",
               name, got, exp, tests_o, k);
      errors_o++;
      test_err++;
   endtask

   initial begin
      tests_o   = 0;
      errors_o  = 0;
      k         = 0;
      test_err  = 0;
      ready_due = 1'b0;
   end

   always @(posedge clk_i) begin
      burst_pkg::word_t  exp_w;
      burst_pkg::beat_cnt_t exp_beats;
      logic              exp_last;
      if (!rst_i) begin
         if (ready_due) begin
            ready_due = 1'b0;
            if (!cmd_ready_i) begin
               $display("cmd_ready_o did not return high after the last word");
               errors_o++;
            end
         end
         if (cmd_valid_i && cmd_ready_i) begin
            cmd_q    = cmd_i;
            k        = 0;
            test_err = 0;
         end
         if (mem_req_valid_i && mem_req_ready_i) begin
            exp_beats = cmd_q.n_words + burst_pkg::beat_cnt_t'(cmd_q.byte_addr[1:0] != 2'b00);
            if (mem_req_i.word_addr != cmd_q.byte_addr[15:2])
               report_error("mem_req_o.word_addr", 32'(mem_req_i.word_addr),
                            32'(cmd_q.byte_addr[15:2]));
            if (mem_req_i.n_beats != exp_beats)
               report_error("mem_req_o.n_beats", 32'(mem_req_i.n_beats), 32'(exp_beats));
         end
         if (out_valid_i && out_ready_i) begin
            exp_w    = expected_word(cmd_q.byte_addr + burst_pkg::byte_addr_t'(4 * k));
            exp_last = (k == int'(cmd_q.n_words) - 1);
            if (out_data_i !== exp_w) report_error("out_data_o", out_data_i, exp_w);
            if (out_last_i !== exp_last) report_error("out_last_o", 32'(out_last_i),
                                                      32'(exp_last));
            k++;
            if (exp_last) begin
               $display("test %0d addr %h words %0d %s", tests_o, cmd_q.byte_addr,
                        cmd_q.n_words, (test_err == 0) ? "ok" : "mismatch");
               tests_o++;
               ready_due = 1'b1;
            end
         end
      end
   end

endmodule

// File: verif/burst_assertions.sv
module burst_assertions (
   input logic                clk_i,
   input logic                rst_i,
   input logic                cmd_ready_i,
   input logic                mem_req_valid_i,
   input logic                mem_req_ready_i,
   input burst_pkg::mem_req_t mem_req_i,
   input logic                mem_data_valid_i,
   input logic                mem_data_ready_i,
   input logic                out_valid_i,
   input logic                out_ready_i
);

   no_cmd_ready_in_burst: assert property (@(posedge clk_i) disable iff (rst_i)
      (mem_req_valid_i || mem_data_ready_i || out_valid_i) |-> !cmd_ready_i)
      else $error("cmd_ready_o high during an active burst");

   out_valid_needs_beat: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_i |-> (mem_data_valid_i && (mem_data_ready_i == out_ready_i)))
      else $error("out_valid_o high without a memory beat or with mem_data_ready_o off out_ready_i");

   req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (mem_req_valid_i && !mem_req_ready_i) |=> (mem_req_valid_i && $stable(mem_req_i)))
      else $error("memory request changed before it was accepted");

endmodule

bind burst_read_top burst_assertions u_assert (
   .clk_i            (clk_i),
   .rst_i            (rst_i),
   .cmd_ready_i      (cmd_ready_o),
   .mem_req_valid_i  (mem_req_valid_o),
   .mem_req_ready_i  (mem_req_ready_i),
   .mem_req_i        (mem_req_o),
   .mem_data_valid_i (mem_data_valid_i),
   .mem_data_ready_i (mem_data_ready_o),
   .out_valid_i      (out_valid_o),
   .out_ready_i      (out_ready_i)
);

// File: verif/tb_clock.sv
module tb_clock (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #2 clk_o = ~clk_o;  // period 4
      end
   end

endmodule

// File: hw/burst_read_top.sv
module burst_read_top (
   input  logic                 clk_i,
   input  logic                 rst_i,

   input  logic                 cmd_valid_i,
   input  burst_pkg::cmd_t      cmd_i,
   output logic                 cmd_ready_o,

   output logic                 mem_req_valid_o,
   output burst_pkg::mem_req_t  mem_req_o,
   input  logic                 mem_req_ready_i,

   input  logic                 mem_data_valid_i,
   input  burst_pkg::word_t     mem_data_i,
   output logic                 mem_data_ready_o,

   output logic                 out_valid_o,
   output burst_pkg::word_t     out_data_o,
   output logic                 out_last_o,
   input  logic                 out_ready_i
);

   burst_pkg::shift_t    shift;
   burst_pkg::beat_cnt_t cnt_val;
   logic                 beat_take;
   logic                 cnt_load;
   logic                 cnt_last;

   burst_ctrl u_ctrl (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .cmd_valid_i      (cmd_valid_i),
      .cmd_i            (cmd_i),
      .cmd_ready_o      (cmd_ready_o),
      .mem_req_valid_o  (mem_req_valid_o),
      .mem_req_o        (mem_req_o),
      .mem_req_ready_i  (mem_req_ready_i),
      .mem_data_valid_i (mem_data_valid_i),
      .mem_data_ready_o (mem_data_ready_o),
      .out_ready_i      (out_ready_i),
      .out_valid_o      (out_valid_o),
      .out_last_o       (out_last_o),
      .shift_o          (shift),
      .beat_take_o      (beat_take),
      .cnt_load_o       (cnt_load),
      .cnt_val_o        (cnt_val),
      .cnt_last_i       (cnt_last)
   );

   beat_counter u_cnt (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .load_i     (cnt_load),
      .load_val_i (cnt_val),
      .dec_i      (beat_take),
      .last_o     (cnt_last)
   );

   burst_split u_split (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .shift_i     (shift),
      .beat_i      (mem_data_i),
      .beat_take_i (beat_take),
      .data_o      (out_data_o)
   );

endmodule

// File: hw/burst_ctrl.sv
module burst_ctrl (
   input  logic                  clk_i,
   input  logic                  rst_i,

   input  logic                  cmd_valid_i,
   input  burst_pkg::cmd_t       cmd_i,
   output logic                  cmd_ready_o,

   output logic                  mem_req_valid_o,
   output burst_pkg::mem_req_t   mem_req_o,
   input  logic                  mem_req_ready_i,

   input  logic                  mem_data_valid_i,
   output logic                  mem_data_ready_o,

   input  logic                  out_ready_i,
   output logic                  out_valid_o,
   output logic                  out_last_o,

   output burst_pkg::shift_t     shift_o,
   output logic                  beat_take_o,
   output logic                  cnt_load_o,
   output burst_pkg::beat_cnt_t  cnt_val_o,
   input  logic                  cnt_last_i
);

   burst_pkg::ctrl_state_e state_q;
   burst_pkg::ctrl_state_e state_d;
   burst_pkg::cmd_t        cmd_q;
   burst_pkg::shift_t      offset;
   logic                   cmd_ready_q;
   logic                   cmd_take;
   logic                   req_take;
   logic                   in_stream;

   assign cmd_take  = cmd_valid_i && cmd_ready_o;
   assign req_take  = mem_req_valid_o && mem_req_ready_i;
   assign in_stream = (state_q == burst_pkg::ST_STREAM);

   // byte offset inside the first word
   assign offset = cmd_q.byte_addr[burst_pkg::SHIFT_W-1:0];

   assign mem_req_o.word_addr = cmd_q.byte_addr[burst_pkg::ADDR_W-1:burst_pkg::SHIFT_W];
   assign mem_req_o.n_beats   = cmd_q.n_words + burst_pkg::beat_cnt_t'(offset != '0);
   assign shift_o = burst_pkg::shift_t'(3'(burst_pkg::BYTES_W) - {1'b0, offset});

   assign cmd_ready_o     = cmd_ready_q;
   assign mem_req_valid_o = (state_q == burst_pkg::ST_REQ);
   assign cnt_load_o      = req_take;
   assign cnt_val_o       = mem_req_o.n_beats;

   always_comb begin
      case (state_q)
         burst_pkg::ST_PRIME:  mem_data_ready_o = 1'b1;
         burst_pkg::ST_STREAM: mem_data_ready_o = out_ready_i;
         default:              mem_data_ready_o = 1'b0;
      endcase
   end

   assign beat_take_o = mem_data_valid_i && mem_data_ready_o;
   assign out_valid_o = in_stream && mem_data_valid_i;
   assign out_last_o  = in_stream && cnt_last_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         burst_pkg::ST_IDLE: begin
            if (cmd_take) state_d = burst_pkg::ST_REQ;
         end
         burst_pkg::ST_REQ: begin
            if (req_take) begin
               state_d = (shift_o != '0) ? burst_pkg::ST_PRIME : burst_pkg::ST_STREAM;
            end
         end
         burst_pkg::ST_PRIME: begin
            if (beat_take_o) state_d = burst_pkg::ST_STREAM;  // first beat fills the store
         end
         default: begin
            if (beat_take_o && out_last_o) state_d = burst_pkg::ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q     <= burst_pkg::ST_IDLE;
         cmd_ready_q <= 1'b0;  // rises one cycle after reset
      end else begin
         state_q     <= state_d;
         cmd_ready_q <= (state_d == burst_pkg::ST_IDLE);
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_take) begin
         cmd_q <= cmd_i;
      end
   end

endmodule

// File: hw/beat_counter.sv
module beat_counter (
   input  logic                 clk_i,
   input  logic                 rst_i,

   input  logic                 load_i,
   input  burst_pkg::beat_cnt_t load_val_i,
   input  logic                 dec_i,

   output logic                 last_o
);

   burst_pkg::beat_cnt_t cnt_q;  // beats still to come

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cnt_q <= '0;
      end else if (load_i) begin
         cnt_q <= load_val_i;
      end else if (dec_i && cnt_q != '0) begin
         cnt_q <= cnt_q - burst_pkg::beat_cnt_t'(1);
      end
   end

   assign last_o = (cnt_q == burst_pkg::beat_cnt_t'(1));

endmodule

// File: hw/burst_split.sv
module burst_split (
   input  logic                  clk_i,
   input  logic                  rst_i,

   input  burst_pkg::shift_t     shift_i,
   input  burst_pkg::word_t      beat_i,
   input  logic                  beat_take_i,

   output burst_pkg::word_t      data_o
);

   // upper three bytes of the previous beat
   logic [burst_pkg::DATA_W-9:0] store_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         store_q <= '0;
      end else if (beat_take_i) begin
         store_q <= beat_i[burst_pkg::DATA_W-1:8];
      end
   end

   // low bytes of the output come from the store, high bytes from the beat
   always_comb begin
      data_o = beat_i;
      case (shift_i)
         2'd1: begin
            data_o = {beat_i[23:0], store_q[23:16]};  // addr mod 4 = 3
         end
         2'd2: begin
            data_o = {beat_i[15:0], store_q[23:8]};   // addr mod 4 = 2
         end
         2'd3: begin
            data_o = {beat_i[7:0], store_q[23:0]};    // addr mod 4 = 1
         end
         default: begin
            data_o = beat_i;                          // aligned pass through
         end
      endcase
   end

endmodule

// File: hw/burst_pkg.sv
package burst_pkg;

   localparam int DATA_W  = 32;
   localparam int BYTES_W = 4;
   localparam int ADDR_W  = 16;
   localparam int LEN_W   = 9;

   localparam int SHIFT_W = $clog2(BYTES_W);  // byte lane select width
   localparam int WADDR_W = ADDR_W - SHIFT_W;

   typedef logic [DATA_W-1:0]  word_t;
   typedef logic [ADDR_W-1:0]  byte_addr_t;
   typedef logic [WADDR_W-1:0] word_addr_t;
   typedef logic [LEN_W-1:0]   beat_cnt_t;
   typedef logic [SHIFT_W-1:0] shift_t;  // (4 - addr mod 4) mod 4

   typedef struct packed {
      byte_addr_t byte_addr;
      beat_cnt_t  n_words;  // 1..255
   } cmd_t;

   typedef struct packed {
      word_addr_t word_addr;
      beat_cnt_t  n_beats;
   } mem_req_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_PRIME,
      ST_STREAM
   } ctrl_state_e;

endpackage
